// File: logic/rvPkg.sv
/* RV32I core shared types */
package rvPkg;

  localparam int xlen = 32;
  localparam int regIdWidth = 5;
  localparam logic [xlen-1:0] pcReset = '0;
  localparam int dmemWords = 1024;
  localparam int dmemIdxWidth = $clog2(dmemWords);
  // addi x0, x0, 0
  localparam logic [xlen-1:0] nopInst = 32'h0000_0013;

  typedef logic [xlen-1:0] rvWord;

  // major opcodes
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opImm    = 7'b0010011,
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,
    opReg    = 7'b0110011,
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111,
    opSystem = 7'b1110011
  } rvOpcode;

  typedef enum logic [4:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluEq,
    aluNe,
    aluLt,
    aluGe,
    aluLtu,
    aluGeu,
    aluPassB
  } rvAluOp;

  typedef enum logic [1:0] {
    widthByte = 2'd0,
    widthHalf = 2'd1,
    widthWord = 2'd2
  } rvWidth;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rvInstR;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rvInstI;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } rvInstS;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } rvInstB;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rvInstU;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rvInstJ;

  typedef union packed {
    rvInstR r;
    rvInstI i;
    rvInstS s;
    rvInstB b;
    rvInstU u;
    rvInstJ j;
  } rvInst;

  typedef struct packed {
    rvAluOp aluOp;
    rvWidth width;
    logic   regWen;
    logic   memWen;
    logic   isLoad;
    logic   isUnsigned;
    logic   isBranch;
    logic   isJal;
    logic   isJalr;
    logic   useImm;
    logic   usePc;
    logic   isEbreak;
    logic   illegal;
  } rvCtrl;

  typedef struct packed {
    logic                  valid;
    rvWord                 pc;
    rvWord                 inst;
    logic                  regWen;
    logic [regIdWidth-1:0] rd;
    rvWord                 rdData;
    logic                  illegal;
  } rvRetire;

endpackage

// File: logic/rvAlu.sv
/* integer ALU */
module rvAlu (
  input  rvPkg::rvWord  a,
  input  rvPkg::rvWord  b,
  input  rvPkg::rvAluOp aluOp,
  output rvPkg::rvWord  result
);

  logic [4:0] shamt;
  logic       lessS;
  logic       lessU;

  assign shamt = b[4:0];
  assign lessS = $signed(a) < $signed(b);
  assign lessU = a < b;

  always_comb begin
    case (aluOp)
      rvPkg::aluAdd:             result = a + b;
      rvPkg::aluSub:             result = a - b;
      rvPkg::aluSll:             result = a << shamt;
      rvPkg::aluXor:             result = a ^ b;
      rvPkg::aluSrl:             result = a >> shamt;
      rvPkg::aluSra:             result = rvPkg::rvWord'($signed(a) >>> shamt);
      rvPkg::aluOr:              result = a | b;
      rvPkg::aluAnd:             result = a & b;
      // compares give 0 or 1, which doubles as the branch condition
      rvPkg::aluSlt, rvPkg::aluLt: begin
        result = {{(rvPkg::xlen-1){1'b0}}, lessS};
      end
      rvPkg::aluSltu, rvPkg::aluLtu: begin
        result = {{(rvPkg::xlen-1){1'b0}}, lessU};
      end
      rvPkg::aluGe:              result = {{(rvPkg::xlen-1){1'b0}}, !lessS};
      rvPkg::aluGeu:             result = {{(rvPkg::xlen-1){1'b0}}, !lessU};
      rvPkg::aluEq:              result = {{(rvPkg::xlen-1){1'b0}}, a == b};
      rvPkg::aluNe:              result = {{(rvPkg::xlen-1){1'b0}}, a != b};
      rvPkg::aluPassB:           result = b;
      default:                   result = '0;
    endcase
  end

endmodule

// File: logic/rvRegFile.sv
/* integer register file */
module rvRegFile (
  input  logic                         clk,
  input  logic [rvPkg::regIdWidth-1:0] rs1,
  input  logic [rvPkg::regIdWidth-1:0] rs2,
  output rvPkg::rvWord                 rdata1,
  output rvPkg::rvWord                 rdata2,
  input  logic                         wen,
  input  logic [rvPkg::regIdWidth-1:0] rd,
  input  rvPkg::rvWord                 wdata
);

  rvPkg::rvWord regs [2**rvPkg::regIdWidth];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 reads zero no matter what the array holds
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: logic/rvDataMem.sv
/* data RAM with load extension */
module rvDataMem (
  input  logic         clk,
  input  rvPkg::rvWord addr,
  input  rvPkg::rvWord wdata,
  input  logic         wen,
  input  logic         ren,
  input  rvPkg::rvWidth width,
  input  logic         isUnsigned,
  output rvPkg::rvWord rdata
);

  rvPkg::rvWord mem [rvPkg::dmemWords];

  logic [rvPkg::dmemIdxWidth-1:0] wordIdx;
  logic [1:0]                     byteOff;
  logic [3:0]                     byteEn;
  rvPkg::rvWord                   laneData;
  rvPkg::rvWord                   readWord;
  rvPkg::rvWord                   shifted;

  assign wordIdx = addr[rvPkg::dmemIdxWidth+1:2];
  assign byteOff = addr[1:0];

  // store data replicated over all lanes, enables pick the ones written
  always_comb begin
    case (width)
      rvPkg::widthByte: begin
        byteEn   = 4'b0001 << byteOff;
        laneData = {4{wdata[7:0]}};
      end
      rvPkg::widthHalf: begin
        byteEn   = 4'b0011 << {byteOff[1], 1'b0};
        laneData = {2{wdata[15:0]}};
      end
      default: begin
        byteEn   = 4'b1111;
        laneData = wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byteEn[lane]) begin
          mem[wordIdx][8*lane +: 8] <= laneData[8*lane +: 8];
        end
      end
    end
  end

  assign readWord = mem[wordIdx];
  // addressed byte or half moved down to bit 0
  assign shifted  = readWord >> {byteOff, 3'b000};

  always_comb begin
    if (!ren) begin
      rdata = '0;
    end else begin
      case (width)
        rvPkg::widthByte: begin
          rdata = {{24{shifted[7] & !isUnsigned}}, shifted[7:0]};
        end
        rvPkg::widthHalf: begin
          rdata = {{16{shifted[15] & !isUnsigned}}, shifted[15:0]};
        end
        default: rdata = readWord;
      endcase
    end
  end

endmodule

// File: logic/rvDecoder.sv
/* RV32I instruction decoder */
module rvDecoder (
  input  rvPkg::rvInst                 inst,
  output logic [rvPkg::regIdWidth-1:0] rd,
  output logic [rvPkg::regIdWidth-1:0] rs1,
  output logic [rvPkg::regIdWidth-1:0] rs2,
  output rvPkg::rvWord                 imm,
  output rvPkg::rvCtrl                 ctrl
);

  // register fields sit at the same bits in every format
  assign rd  = inst.r.rd;
  assign rs1 = inst.r.rs1;
  assign rs2 = inst.r.rs2;

  // shared funct3 mapping of OP and OP-IMM
  function automatic rvPkg::rvAluOp baseOp(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'd0:    baseOp = alt ? rvPkg::aluSub : rvPkg::aluAdd;
      3'd1:    baseOp = rvPkg::aluSll;
      3'd2:    baseOp = rvPkg::aluSlt;
      3'd3:    baseOp = rvPkg::aluSltu;
      3'd4:    baseOp = rvPkg::aluXor;
      3'd5:    baseOp = alt ? rvPkg::aluSra : rvPkg::aluSrl;
      3'd6:    baseOp = rvPkg::aluOr;
      default: baseOp = rvPkg::aluAnd;
    endcase
  endfunction

  always_comb begin
    case (inst.r.opcode)
      rvPkg::opStore:
        imm = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
      rvPkg::opBranch:
        imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
               inst.b.imm10to5, inst.b.imm4to1, 1'b0};
      rvPkg::opLui, rvPkg::opAuipc:
        imm = {inst.u.imm, 12'b0};
      rvPkg::opJal:
        imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19to12,
               inst.j.imm11, inst.j.imm10to1, 1'b0};
      default:
        imm = {{20{inst.i.imm[11]}}, inst.i.imm};
    endcase
  end

  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = rvPkg::aluAdd;
    ctrl.width = rvPkg::widthWord;
    case (inst.r.opcode)
      rvPkg::opLui: begin
        ctrl.aluOp  = rvPkg::aluPassB;
        ctrl.regWen = 1'b1;
        ctrl.useImm = 1'b1;
      end
      rvPkg::opAuipc, rvPkg::opJal: begin
        ctrl.regWen = 1'b1;
        ctrl.useImm = 1'b1;
        ctrl.usePc  = 1'b1;
        ctrl.isJal  = (inst.r.opcode == rvPkg::opJal);
      end
      rvPkg::opJalr: begin
        ctrl.regWen  = 1'b1;
        ctrl.useImm  = 1'b1;
        ctrl.isJalr  = 1'b1;
        ctrl.illegal = (inst.i.funct3 != 3'd0);
      end
      rvPkg::opBranch: begin
        ctrl.isBranch = 1'b1;
        case (inst.b.funct3)
          3'd0:    ctrl.aluOp = rvPkg::aluEq;
          3'd1:    ctrl.aluOp = rvPkg::aluNe;
          3'd4:    ctrl.aluOp = rvPkg::aluLt;
          3'd5:    ctrl.aluOp = rvPkg::aluGe;
          3'd6:    ctrl.aluOp = rvPkg::aluLtu;
          3'd7:    ctrl.aluOp = rvPkg::aluGeu;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      rvPkg::opLoad: begin
        ctrl.regWen     = 1'b1;
        ctrl.isLoad     = 1'b1;
        ctrl.useImm     = 1'b1;
        ctrl.isUnsigned = inst.i.funct3[2];
        ctrl.width      = rvPkg::rvWidth'(inst.i.funct3[1:0]);
        ctrl.illegal    = (inst.i.funct3 == 3'd3) || (inst.i.funct3 > 3'd5);
      end
      rvPkg::opStore: begin
        ctrl.memWen  = 1'b1;
        ctrl.useImm  = 1'b1;
        ctrl.width   = rvPkg::rvWidth'(inst.s.funct3[1:0]);
        ctrl.illegal = (inst.s.funct3 > 3'd2);
      end
      rvPkg::opImm: begin
        ctrl.regWen = 1'b1;
        ctrl.useImm = 1'b1;
        ctrl.aluOp  = baseOp(inst.i.funct3, inst.i.funct3 == 3'd5 && inst.r.funct7[5]);
        // shift immediates only allow the srai marker bit
        if (inst.i.funct3 == 3'd1) begin
          ctrl.illegal = (inst.r.funct7 != 7'd0);
        end else if (inst.i.funct3 == 3'd5) begin
          ctrl.illegal = (inst.r.funct7 & 7'b101_1111) != 7'd0;
        end
      end
      rvPkg::opReg: begin
        ctrl.regWen  = 1'b1;
        ctrl.aluOp   = baseOp(inst.r.funct3, inst.r.funct7[5]);
        ctrl.illegal = (inst.r.funct7 == 7'b010_0000)
                       ? !(inst.r.funct3 == 3'd0 || inst.r.funct3 == 3'd5)
                       : (inst.r.funct7 != 7'd0);
      end
      rvPkg::opSystem: begin
        // only ebreak is implemented here
        if (inst.i.imm == 12'd1 && inst.i.rs1 == '0 && inst.i.funct3 == 3'd0 &&
            inst.i.rd == '0) begin
          ctrl.isEbreak = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
    if (ctrl.illegal) begin
      ctrl         = '0;
      ctrl.illegal = 1'b1;
    end
  end

endmodule

// File: logic/rvCore.sv
/* two-stage RV32I core */
module rvCore (
  input  logic           clk,
  input  logic           rstN,
  output rvPkg::rvWord    pcFetch,
  input  rvPkg::rvWord    inst,
  output rvPkg::rvRetire  retire,
  output logic           halted,
  output logic           illegalSeen
);

  // IF/ID register
  logic         idValid;
  rvPkg::rvWord idPc;
  rvPkg::rvWord idInst;

  logic [rvPkg::regIdWidth-1:0] rd;
  logic [rvPkg::regIdWidth-1:0] rs1;
  logic [rvPkg::regIdWidth-1:0] rs2;
  rvPkg::rvWord                 imm;
  rvPkg::rvCtrl                 ctrl;

  rvPkg::rvWord rdata1;
  rvPkg::rvWord rdata2;
  rvPkg::rvWord aluA;
  rvPkg::rvWord aluB;
  rvPkg::rvWord aluResult;
  rvPkg::rvWord loadData;
  rvPkg::rvWord wbData;
  rvPkg::rvWord linkAddr;
  rvPkg::rvWord nextPc;

  logic isJump;
  logic takenXfer;
  logic haltNow;
  logic flush;
  logic regWen;

  rvDecoder decoder (
    .inst (idInst),
    .rd   (rd),
    .rs1  (rs1),
    .rs2  (rs2),
    .imm  (imm),
    .ctrl (ctrl)
  );

  // a bubble never writes anything
  assign regWen = ctrl.regWen & idValid;

  rvRegFile regFile (
    .clk    (clk),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (regWen),
    .rd     (rd),
    .wdata  (wbData)
  );

  assign aluA = ctrl.usePc ? idPc : rdata1;
  assign aluB = ctrl.useImm ? imm : rdata2;

  rvAlu alu (
    .a      (aluA),
    .b      (aluB),
    .aluOp  (ctrl.aluOp),
    .result (aluResult)
  );

  rvDataMem dataMem (
    .clk        (clk),
    .addr       (aluResult),
    .wdata      (rdata2),
    .wen        (ctrl.memWen & idValid),
    .ren        (ctrl.isLoad & idValid),
    .width      (ctrl.width),
    .isUnsigned (ctrl.isUnsigned),
    .rdata      (loadData)
  );

  assign isJump    = idValid & (ctrl.isJal | ctrl.isJalr);
  assign takenXfer = isJump | (idValid & ctrl.isBranch & aluResult[0]);
  assign haltNow   = idValid & ctrl.isEbreak;
  // ebreak also empties IF/ID so nothing runs behind it
  assign flush     = takenXfer | haltNow;
  assign linkAddr  = idPc + 32'd4;

  always_comb begin
    if (isJump) begin
      nextPc = aluResult & ~32'd1;
    end else if (takenXfer) begin
      nextPc = idPc + imm;
    end else begin
      nextPc = pcFetch + 32'd4;
    end
  end

  assign wbData = (ctrl.isJal | ctrl.isJalr) ? linkAddr
                : ctrl.isLoad ? loadData
                : aluResult;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcFetch     <= rvPkg::pcReset;
      idValid     <= 1'b0;
      idInst      <= rvPkg::nopInst;
      halted      <= 1'b0;
      illegalSeen <= 1'b0;
    end else if (!halted) begin
      pcFetch <= nextPc;
      idValid <= !flush;
      idInst  <= flush ? rvPkg::nopInst : inst;
      halted  <= haltNow;
      if (idValid && ctrl.illegal) begin
        illegalSeen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!halted) begin
      idPc <= pcFetch;
    end
  end

  // trace of the instruction in the ID stage
  always_comb begin
    retire.valid   = idValid;
    retire.pc      = idPc;
    retire.inst    = idInst;
    retire.regWen  = regWen;
    retire.rd      = rd;
    retire.rdData  = wbData;
    retire.illegal = idValid & ctrl.illegal;
  end

endmodule

// File: test/rvCore_asserts.sv
/* core control assertions */
module rvCoreAsserts (
  input logic           clk,
  input logic           rstN,
  input rvPkg::rvWord   pcFetch,
  input rvPkg::rvRetire retire,
  input logic           halted,
  input logic           takenXfer
);
  timeunit 1ns;
  timeprecision 100ps;

  // first edge after reset release sees a clean pipeline
  resetClean: assert property (@(posedge clk) $rose(rstN) |-> !retire.valid && !halted)
    else $error("retire or halt active on the first edge after reset");

  haltFreeze: assert property (@(posedge clk) disable iff (!rstN)
    halted |=> $stable(pcFetch))
    else $error("fetch pc moved while halted");

  illegalNoWrite: assert property (@(posedge clk) disable iff (!rstN)
    retire.valid && retire.illegal |-> !retire.regWen)
    else $error("illegal instruction retired with a register write");

  // one bubble behind every taken transfer
  flushBubble: assert property (@(posedge clk) disable iff (!rstN)
    takenXfer |=> !retire.valid)
    else $error("instruction retired right after a taken transfer");

endmodule

bind rvCore rvCoreAsserts coreAsserts (
  .clk       (clk),
  .rstN      (rstN),
  .pcFetch   (pcFetch),
  .retire    (retire),
  .halted    (halted),
  .takenXfer (takenXfer)
);

// File: test/rvCoreTb.sv
/* RV32I core testbench */
module rvCoreTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam rvPkg::rvWord ebreakInst = 32'h0010_0073;
  localparam logic [31:0] lfsrSeed = 32'hf591_befe;
  localparam rvPkg::rvWord memBase = 32'h0000_0100;

  typedef struct packed {
    rvPkg::rvWord                 pc;
    rvPkg::rvWord                 data;
    logic [rvPkg::regIdWidth-1:0] rd;
    logic                         chk;
  } expEntry;

  logic            clk = 1'b0;
  logic            rstN;
  rvPkg::rvWord    pcFetch;
  rvPkg::rvWord    inst;
  rvPkg::rvRetire  retire;
  logic            halted;
  logic            illegalSeen;

  rvPkg::rvWord   prog [256];
  int             progLen;
  expEntry        expQ [$];
  rvPkg::rvRetire trace [$];
  logic [7:0]     shadow [16];
  logic [31:0]    lfsrState;
  string          testName;
  int             errors = 0;
  int             cycles = 0;
  int             cycleLimit = 200;

  rvCore DUT (
    .clk         (clk),
    .rstN        (rstN),
    .pcFetch     (pcFetch),
    .inst        (inst),
    .retire      (retire),
    .halted      (halted),
    .illegalSeen (illegalSeen)
  );

  always #2 clk = ~clk;

  // instruction ROM, anything past the image reads as ebreak
  assign inst = (pcFetch < 32'd1024) ? prog[pcFetch[9:2]] : ebreakInst;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout: the core did not halt within %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic rvPkg::rvWord randBits(int n);
    rvPkg::rvWord w;
    int i;
    w = '0;
    for (i = 0; i < n; i++) begin
      w = {w[30:0], lfsrStep()};
    end
    return w;
  endfunction

  function automatic rvPkg::rvWord encR(int f7, int rs2, int rs1, int f3, int rd,
                                       rvPkg::rvOpcode op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic rvPkg::rvWord encI(int imm, int rs1, int f3, int rd, rvPkg::rvOpcode op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic rvPkg::rvWord encS(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rvPkg::opStore};
  endfunction

  function automatic rvPkg::rvWord encB(int off, int rs1, int rs2, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
            rvPkg::opBranch};
  endfunction

  function automatic rvPkg::rvWord encU(int imm20, int rd, rvPkg::rvOpcode op);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic rvPkg::rvWord encJ(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rvPkg::opJal};
  endfunction

  // RV32I result by funct3, alt selects sub and sra
  function automatic rvPkg::rvWord aluRef(int f3, bit alt, rvPkg::rvWord a, rvPkg::rvWord b);
    case (f3)
      0:       return alt ? a - b : a + b;
      1:       return a << b[4:0];
      2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3:       return (a < b) ? 32'd1 : 32'd0;
      4:       return a ^ b;
      5:       return alt ? rvPkg::rvWord'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6:       return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branchRef(int f3, rvPkg::rvWord a, rvPkg::rvWord b);
    case (f3)
      0:       return a == b;
      1:       return a != b;
      4:       return $signed(a) < $signed(b);
      5:       return $signed(a) >= $signed(b);
      6:       return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic storeRef(int off, rvPkg::rvWord data, int f3);
    int i;
    for (i = 0; i < (1 << f3); i++) begin
      shadow[off + i] = data[8*i +: 8];
    end
  endtask

  function automatic rvPkg::rvWord loadRef(int off, int f3);
    case (f3)
      0:       return {{24{shadow[off][7]}}, shadow[off]};
      4:       return {24'h0, shadow[off]};
      1:       return {{16{shadow[off+1][7]}}, shadow[off+1], shadow[off]};
      5:       return {16'h0, shadow[off+1], shadow[off]};
      default: return {shadow[off+3], shadow[off+2], shadow[off+1], shadow[off]};
    endcase
  endfunction

  task automatic checkWord(string what, rvPkg::rvWord expVal, rvPkg::rvWord actVal);
    if (actVal !== expVal) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", testName, what, expVal, actVal);
    end
  endtask

  task automatic checkRegId(string what, logic [rvPkg::regIdWidth-1:0] expVal,
                            logic [rvPkg::regIdWidth-1:0] actVal);
    if (actVal !== expVal) begin
      errors++;
      $display("FAILED %s %s: expected x%0d, actual x%0d", testName, what, expVal, actVal);
    end
  endtask

  task automatic checkFlag(string what, logic expVal, logic actVal);
    if (actVal !== expVal) begin
      errors++;
      $display("FAILED %s %s: expected %b, actual %b", testName, what, expVal, actVal);
    end
  endtask

  task automatic clearProgram();
    foreach (prog[i]) begin
      prog[i] = ebreakInst;
    end
    progLen = 0;
    expQ.delete();
  endtask

  task automatic emitSkipped(rvPkg::rvWord w);
    prog[progLen] = w;
    progLen++;
  endtask

  task automatic emitExpected(rvPkg::rvWord w, rvPkg::rvWord data, logic chk);
    expEntry e;
    e.pc   = progLen * 4;
    e.data = data;
    // destination field of the encoding
    e.rd   = w[11:7];
    e.chk  = chk;
    expQ.push_back(e);
    emitSkipped(w);
  endtask

  task automatic emitWithData(rvPkg::rvWord w, rvPkg::rvWord data);
    emitExpected(w, data, 1'b1);
  endtask

  task automatic emitTraced(rvPkg::rvWord w);
    emitExpected(w, '0, 1'b0);
  endtask

  // lui and addi, upper part rounded for the signed low part
  task automatic loadConst(int rd, rvPkg::rvWord value);
    rvPkg::rvWord upper;
    upper = value + 32'h800;
    upper[11:0] = '0;
    emitWithData(encU(upper[31:12], rd, rvPkg::opLui), upper);
    emitWithData(encI(value[11:0], rd, 0, rd, rvPkg::opImm), value);
  endtask

  // appends ebreak, resets and collects retires until the core halts
  task automatic runProgram();
    emitTraced(ebreakInst);
    cycleLimit += progLen * 4;
    trace.delete();
    @(posedge clk);
    #1;
    rstN = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    checkWord("pc in reset", rvPkg::pcReset, pcFetch);
    checkFlag("halted in reset", 1'b0, halted);
    checkFlag("retire valid in reset", 1'b0, retire.valid);
    rstN = 1'b1;
    while (!halted) begin
      @(negedge clk);
      if (retire.valid) begin
        trace.push_back(retire);
      end
    end
  endtask

  task automatic checkTrace();
    int n;
    int i;
    n = (trace.size() < expQ.size()) ? trace.size() : expQ.size();
    if (trace.size() != expQ.size()) begin
      errors++;
      $display("%s: %0d instructions retired where %0d were expected",
               testName, trace.size(), expQ.size());
    end
    for (i = 0; i < n; i++) begin
      checkWord($sformatf("pc[%0d]", i), expQ[i].pc, trace[i].pc);
      if (expQ[i].chk) begin
        checkWord($sformatf("rdData[%0d]", i), expQ[i].data, trace[i].rdData);
        checkRegId($sformatf("rd[%0d]", i), expQ[i].rd, trace[i].rd);
        checkFlag($sformatf("regWen[%0d]", i), 1'b1, trace[i].regWen);
      end
    end
  endtask

  task automatic testAlu();
    rvPkg::rvWord a;
    rvPkg::rvWord b;
    rvPkg::rvWord im;
    rvPkg::rvWord immVal;
    rvPkg::rvWord u20;
    int f3;
    int immF3 [6] = '{0, 2, 3, 4, 6, 7};
    testName = "alu";
    clearProgram();
    a = randBits(32);
    b = randBits(32);
    loadConst(1, a);
    loadConst(2, b);
    for (f3 = 0; f3 < 8; f3++) begin
      emitWithData(encR(0, 2, 1, f3, 3 + f3, rvPkg::opReg), aluRef(f3, 1'b0, a, b));
    end
    emitWithData(encR(32, 2, 1, 0, 11, rvPkg::opReg), aluRef(0, 1'b1, a, b));
    emitWithData(encR(32, 2, 1, 5, 12, rvPkg::opReg), aluRef(5, 1'b1, a, b));
    foreach (immF3[k]) begin
      im = randBits(12);
      immVal = {{20{im[11]}}, im[11:0]};
      emitWithData(encI(im, 1, immF3[k], 13, rvPkg::opImm), aluRef(immF3[k], 1'b0, a, immVal));
    end
    im = randBits(5);
    emitWithData(encI(im, 1, 1, 13, rvPkg::opImm), aluRef(1, 1'b0, a, im));
    emitWithData(encI(im, 1, 5, 13, rvPkg::opImm), aluRef(5, 1'b0, a, im));
    emitWithData(encI({7'b010_0000, im[4:0]}, 1, 5, 13, rvPkg::opImm), aluRef(5, 1'b1, a, im));
    u20 = randBits(20);
    emitWithData(encU(u20, 14, rvPkg::opAuipc), progLen * 4 + {u20[19:0], 12'h0});
    // write to x0 is dropped, then x0 is read back
    emitTraced(encR(0, 2, 1, 0, 0, rvPkg::opReg));
    emitWithData(encR(0, 0, 0, 0, 15, rvPkg::opReg), '0);
    runProgram();
    checkTrace();
    checkFlag("illegalSeen", 1'b0, illegalSeen);
  endtask

  task automatic testBranch();
    int brF3 [6] = '{0, 1, 4, 5, 6, 7};
    int srcA [3] = '{1, 2, 2};
    int srcB [3] = '{2, 3, 1};
    rvPkg::rvWord regVal [4];
    rvPkg::rvWord skipInst;
    testName = "branch";
    clearProgram();
    regVal[0] = '0;
    regVal[1] = 32'hffff_fffb;
    regVal[2] = 32'd3;
    regVal[3] = 32'd3;
    emitWithData(encI(-5, 0, 0, 1, rvPkg::opImm), regVal[1]);
    emitWithData(encI(3, 0, 0, 2, rvPkg::opImm), regVal[2]);
    emitWithData(encI(3, 0, 0, 3, rvPkg::opImm), regVal[3]);
    skipInst = encI(1, 0, 0, 5, rvPkg::opImm);
    // each pair gives every branch at least one taken and one fall-through case
    foreach (brF3[i]) begin
      foreach (srcA[p]) begin
        emitTraced(encB(8, srcA[p], srcB[p], brF3[i]));
        if (branchRef(brF3[i], regVal[srcA[p]], regVal[srcB[p]])) begin
          emitSkipped(skipInst);
        end else begin
          emitWithData(skipInst, 32'd1);
        end
      end
    end
    runProgram();
    checkTrace();
  endtask

  task automatic testJump();
    rvPkg::rvWord base;
    rvPkg::rvWord target;
    testName = "jump";
    clearProgram();
    base = 32'd30;
    emitWithData(encI(base, 0, 0, 1, rvPkg::opImm), base);
    target = progLen * 4 + 12;
    emitWithData(encJ(12, 5), progLen * 4 + 4);
    while (progLen * 4 < target) begin
      emitSkipped(encI(1, 0, 0, 7, rvPkg::opImm));
    end
    // odd sum, bit 0 must be dropped
    target = (base + 32'd3) & ~32'd1;
    emitWithData(encI(3, 1, 0, 6, rvPkg::opJalr), progLen * 4 + 4);
    while (progLen * 4 < target) begin
      emitSkipped(encI(2, 0, 0, 7, rvPkg::opImm));
    end
    emitWithData(encI(4, 0, 0, 8, rvPkg::opImm), 32'd4);
    runProgram();
    checkTrace();
  endtask

  task automatic testMemory();
    rvPkg::rvWord d [4];
    int stOff [7] = '{1, 6, 2, 8, 15, 12, 11};
    int stReg [7] = '{3, 2, 3, 2, 3, 2, 2};
    int stF3 [7] = '{0, 0, 1, 1, 0, 1, 0};
    int ldF3 [5] = '{0, 1, 2, 4, 5};
    int off;
    testName = "memory";
    clearProgram();
    d[2] = randBits(32);
    d[3] = randBits(32);
    loadConst(1, memBase);
    loadConst(2, d[2]);
    loadConst(3, d[3]);
    // whole words first so every shadow byte is known
    for (off = 0; off < 16; off += 4) begin
      emitTraced(encS(off, (off < 8) ? 2 : 3, 1, 2));
      storeRef(off, d[(off < 8) ? 2 : 3], 2);
    end
    foreach (stOff[i]) begin
      emitTraced(encS(stOff[i], stReg[i], 1, stF3[i]));
      storeRef(stOff[i], d[stReg[i]], stF3[i]);
    end
    foreach (ldF3[k]) begin
      for (off = 0; off < 16; off += (1 << (ldF3[k] & 3))) begin
        emitWithData(encI(off, 1, ldF3[k], 10, rvPkg::opLoad), loadRef(off, ldF3[k]));
      end
    end
    runProgram();
    checkTrace();
  endtask

  task automatic testIllegal();
    rvPkg::rvWord badPc [2];
    testName = "illegal";
    clearProgram();
    emitWithData(encI(5, 0, 0, 4, rvPkg::opImm), 32'd5);
    // custom-0 opcode aimed at x4, then an all-zero word
    badPc[0] = progLen * 4;
    emitTraced(32'h0000_020b);
    badPc[1] = progLen * 4;
    emitTraced(32'h0000_0000);
    emitWithData(encI(0, 4, 0, 6, rvPkg::opImm), 32'd5);
    runProgram();
    checkTrace();
    foreach (trace[i]) begin
      checkFlag($sformatf("illegal[%0d]", i),
                (trace[i].pc == badPc[0]) || (trace[i].pc == badPc[1]), trace[i].illegal);
      if (trace[i].illegal) begin
        checkFlag($sformatf("regWen[%0d]", i), 1'b0, trace[i].regWen);
      end
    end
    checkFlag("illegalSeen", 1'b1, illegalSeen);
  endtask

  task automatic testHalt();
    rvPkg::rvWord held;
    testName = "halt";
    clearProgram();
    emitWithData(encI(9, 0, 0, 1, rvPkg::opImm), 32'd9);
    // sits behind the closing ebreak and must never run
    prog[progLen + 1] = encI(7, 0, 0, 2, rvPkg::opImm);
    runProgram();
    checkTrace();
    if (trace.size() > 0) begin
      checkWord("last retired inst", ebreakInst, trace[trace.size() - 1].inst);
    end
    held = pcFetch;
    repeat (6) begin
      @(negedge clk);
      checkFlag("halted", 1'b1, halted);
      checkFlag("retire valid", 1'b0, retire.valid);
      checkWord("pcFetch", held, pcFetch);
    end
  endtask

  initial begin
    rstN = 1'b0;
    lfsrState = lfsrSeed;
    progLen = 0;
    foreach (prog[i]) begin
      prog[i] = ebreakInst;
    end
    testAlu();
    testBranch();
    testJump();
    testMemory();
    testIllegal();
    testHalt();
    $display("checks done, error count: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: all.f
logic/rvPkg.sv
logic/rvAlu.sv
logic/rvRegFile.sv
logic/rvDataMem.sv
logic/rvDecoder.sv
logic/rvCore.sv
test/rvCore_asserts.sv
test/rvCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
